// ==== verilog/memCtrlPkg.sv ====
package memCtrlPkg;

    // bus widths
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [WORD_W-1:0] wordT;
    typedef logic [BYTE_W-1:0] memByteT;

    // transfer length in bytes, legal values 1, 2, 4
    typedef logic [2:0] lenT;

    // byte position inside a transfer
    typedef logic [2:0] byteIdxT;

    // which port holds the RAM, same codes as the core's wait bus
    typedef enum logic [1:0] {
        OWN_NONE = 2'b00,
        OWN_DATA = 2'b01,
        OWN_INST = 2'b10
    } ownerE;

    typedef enum logic {
        ACC_LOAD  = 1'b0,
        ACC_STORE = 1'b1
    } accessE;

endpackage

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_freeze,

    // data load/store port
    input  logic                 i_dataEn,
    input  memCtrlPkg::accessE   i_dataKind,
    input  memCtrlPkg::lenT      i_dataLen,
    input  memCtrlPkg::addrT     i_dataAddr,
    input  memCtrlPkg::wordT     i_dataWr,

    // instruction fetch port
    input  logic                 i_instEn,
    input  memCtrlPkg::addrT     i_instAddr,

    // progress from sequencer and assembler
    input  logic                 i_lastIssue,
    input  logic                 i_wordReady,

    // latched transfer
    output logic                 o_go,
    output memCtrlPkg::ownerE    o_owner,
    output memCtrlPkg::accessE   o_kind,
    output memCtrlPkg::addrT     o_base,
    output memCtrlPkg::lenT      o_len,
    output memCtrlPkg::wordT     o_storeWord,

    output logic                 o_dataDone,
    output logic                 o_instDone
);
    import memCtrlPkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_FINISH
    } stateE;

    stateE state;
    ownerE owner;
    logic  doneNow;

    // accept only from idle, and never while frozen
    assign o_go = (state == ST_IDLE) && !i_freeze && (i_dataEn || i_instEn);

    // stores finish right after the last write, reads when the last byte is back
    assign doneNow = (state == ST_FINISH) && !i_freeze &&
                     ((o_kind == ACC_STORE) || i_wordReady);

    assign o_dataDone = doneNow && (owner == OWN_DATA);
    assign o_instDone = doneNow && (owner == OWN_INST);
    assign o_owner    = owner;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            owner  <= OWN_NONE;
            o_kind <= ACC_LOAD;
            o_base <= '0;
            o_len  <= '0;
        end else if (!i_freeze) begin
            case (state)
                ST_IDLE: begin
                    // data port has priority over fetch
                    if (i_dataEn) begin
                        state  <= ST_BUSY;
                        owner  <= OWN_DATA;
                        o_kind <= i_dataKind;
                        o_base <= i_dataAddr;
                        o_len  <= i_dataLen;
                    end else if (i_instEn) begin
                        state  <= ST_BUSY;
                        owner  <= OWN_INST;
                        o_kind <= ACC_LOAD;
                        o_base <= i_instAddr;
                        o_len  <= lenT'(BYTES_PER_WORD);
                    end
                end
                ST_BUSY: begin
                    if (i_lastIssue) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (doneNow) begin
                        state <= ST_IDLE;
                        owner <= OWN_NONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    owner <= OWN_NONE;
                end
            endcase
        end
    end

    // store data only matters for a granted store
    always_ff @(posedge clk) begin
        if (o_go && i_dataEn) begin
            o_storeWord <= i_dataWr;
        end
    end

endmodule

// ==== verilog/memSequencer.sv ====
`timescale 1ns/1ps

module memSequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_freeze,

    // transfer from the arbiter
    input  logic                 i_go,
    input  memCtrlPkg::accessE   i_kind,
    input  memCtrlPkg::addrT     i_base,
    input  memCtrlPkg::lenT      i_len,
    input  memCtrlPkg::wordT     i_storeWord,

    // RAM side
    output memCtrlPkg::addrT     o_memAddr,
    output logic                 o_memWe,
    output memCtrlPkg::memByteT  o_memWrByte,

    output logic                 o_lastIssue,
    output logic                 o_readReturn,
    output memCtrlPkg::byteIdxT  o_returnIdx
);
    import memCtrlPkg::*;

    logic    active;
    logic    issue;
    logic    isStore;
    byteIdxT cnt;
    byteIdxT addrIdx;

    assign isStore = (i_kind == ACC_STORE);
    assign issue   = active && !i_freeze;

    assign o_lastIssue = active && (cnt == byteIdxT'(i_len - 3'd1));

    // keep the RAM pointed at a read still in flight while frozen,
    // so its byte is still on the bus when the freeze lifts
    assign addrIdx   = (i_freeze && o_readReturn) ? o_returnIdx : cnt;
    assign o_memAddr = i_base + addrT'(addrIdx);

    assign o_memWe     = issue && isStore;
    assign o_memWrByte = i_storeWord[{cnt[1:0], 3'b000} +: BYTE_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (i_go) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (issue) begin
            if (o_lastIssue) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // read data shows up one cycle after its address
    always_ff @(posedge clk) begin
        if (rst) begin
            o_readReturn <= 1'b0;
            o_returnIdx  <= '0;
        end else if (!i_freeze) begin
            o_readReturn <= issue && !isStore;
            o_returnIdx  <= cnt;
        end
    end

endmodule

// ==== verilog/byteAssembler.sv ====
`timescale 1ns/1ps

module byteAssembler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_freeze,

    input  logic                 i_readReturn,
    input  memCtrlPkg::byteIdxT  i_returnIdx,
    input  memCtrlPkg::lenT      i_len,
    input  memCtrlPkg::memByteT  i_memRdByte,

    output logic                 o_wordReady,
    output memCtrlPkg::wordT     o_word
);
    import memCtrlPkg::*;

    memByteT held [BYTES_PER_WORD];
    logic    lastByte;

    assign lastByte    = i_readReturn && (i_returnIdx == byteIdxT'(i_len - 3'd1));
    assign o_wordReady = lastByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                held[i] <= '0;
            end
        end else if (!i_freeze && i_readReturn) begin
            if (lastByte) begin
                // empty again for the next transfer
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    held[i] <= '0;
                end
            end else begin
                held[i_returnIdx[1:0]] <= i_memRdByte;
            end
        end
    end

    // last byte comes straight from the RAM, unused upper bytes stay zero
    always_comb begin
        o_word = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (lastByte && (i_returnIdx[1:0] == 2'(i))) begin
                o_word[i*BYTE_W +: BYTE_W] = i_memRdByte;
            end else begin
                o_word[i*BYTE_W +: BYTE_W] = held[i];
            end
        end
    end

endmodule

// ==== verilog/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioBufferFull,

    // byte-wide RAM
    input  memCtrlPkg::memByteT  i_memRdByte,
    output memCtrlPkg::addrT     o_memAddr,
    output logic                 o_memWe,
    output memCtrlPkg::memByteT  o_memWrByte,

    output memCtrlPkg::ownerE    o_owner,

    // instruction fetch
    input  logic                 i_instEn,
    input  memCtrlPkg::addrT     i_instAddr,
    output logic                 o_instDone,
    output memCtrlPkg::wordT     o_instWord,

    // data load/store
    input  logic                 i_dataEn,
    input  memCtrlPkg::accessE   i_dataKind,
    input  memCtrlPkg::lenT      i_dataLen,
    input  memCtrlPkg::addrT     i_dataAddr,
    input  memCtrlPkg::wordT     i_dataWr,
    output logic                 o_dataDone,
    output memCtrlPkg::wordT     o_dataRd
);
    import memCtrlPkg::*;

    logic    freeze;
    logic    go;
    logic    lastIssue;
    logic    wordReady;
    logic    readReturn;
    accessE  kind;
    addrT    base;
    lenT     len;
    wordT    storeWord;
    wordT    word;
    byteIdxT returnIdx;

    // whole controller stalls on either condition
    assign freeze = !i_rdy || i_ioBufferFull;

    memArbiter u_memArbiter (
        .clk(clk), .rst(rst), .i_freeze(freeze),
        .i_dataEn(i_dataEn), .i_dataKind(i_dataKind), .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr), .i_dataWr(i_dataWr),
        .i_instEn(i_instEn), .i_instAddr(i_instAddr),
        .i_lastIssue(lastIssue), .i_wordReady(wordReady),
        .o_go(go), .o_owner(o_owner), .o_kind(kind), .o_base(base), .o_len(len),
        .o_storeWord(storeWord), .o_dataDone(o_dataDone), .o_instDone(o_instDone)
    );

    memSequencer u_memSequencer (
        .clk(clk), .rst(rst), .i_freeze(freeze),
        .i_go(go), .i_kind(kind), .i_base(base), .i_len(len), .i_storeWord(storeWord),
        .o_memAddr(o_memAddr), .o_memWe(o_memWe), .o_memWrByte(o_memWrByte),
        .o_lastIssue(lastIssue), .o_readReturn(readReturn), .o_returnIdx(returnIdx)
    );

    byteAssembler u_byteAssembler (
        .clk(clk), .rst(rst), .i_freeze(freeze),
        .i_readReturn(readReturn), .i_returnIdx(returnIdx), .i_len(len),
        .i_memRdByte(i_memRdByte), .o_wordReady(wordReady), .o_word(word)
    );

    // each done already carries the owner, so it steers the word
    assign o_instWord = o_instDone ? word : '0;
    assign o_dataRd   = o_dataDone ? word : '0;

endmodule

// ==== tests/tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tests/memCtrlTb.sv ====
`timescale 1ns/1ps

module memCtrlTb;
    import memCtrlPkg::*;

    localparam logic [31:0] SEED = 32'h2ef50c23;
    localparam int NUM_FETCH = 20;
    localparam int NUM_LOAD  = 30;
    localparam int NUM_STORE = 30;
    localparam int NUM_PAIR  = 10;
    localparam int NUM_MIXED = 40;
    // pairs count twice and a mixed step may be a pair
    localparam int NUM_TRANSFERS  = NUM_FETCH + NUM_LOAD + NUM_STORE + 2 * NUM_PAIR
                                  + 2 * NUM_MIXED;
    localparam int TIMEOUT_CYCLES = 40 * NUM_TRANSFERS + 100;
    localparam int DONE_WAIT      = 80;

    logic    clk;
    logic    rst;
    logic    rdy;
    logic    ioBufferFull;
    memByteT memRdByte = '0;
    addrT    memAddr;
    logic    memWe;
    memByteT memWrByte;
    ownerE   owner;
    logic    instEn;
    addrT    instAddr;
    logic    instDone;
    wordT    instWord;
    logic    dataEn;
    accessE  dataKind;
    lenT     dataLen;
    addrT    dataAddr;
    wordT    dataWr;
    logic    dataDone;
    wordT    dataRd;

    memByteT ram [256];
    memByteT shadow [256];
    wordT    expInstQ [$];
    wordT    expDataQ [$];
    logic    dataIsLoadQ [$];
    logic    dataPending;
    logic    instPending;
    logic    freezeOn;
    logic    frozen;
    int      cycleCount;

    assign frozen = !rdy || ioBufferFull;

    tbClockGen u_tbClockGen (.clk(clk), .rst(rst));

    memCtrl u_memCtrl (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull),
        .i_memRdByte(memRdByte), .o_memAddr(memAddr), .o_memWe(memWe),
        .o_memWrByte(memWrByte), .o_owner(owner),
        .i_instEn(instEn), .i_instAddr(instAddr), .o_instDone(instDone),
        .o_instWord(instWord),
        .i_dataEn(dataEn), .i_dataKind(dataKind), .i_dataLen(dataLen),
        .i_dataAddr(dataAddr), .i_dataWr(dataWr), .o_dataDone(dataDone),
        .o_dataRd(dataRd)
    );

    // byte RAM with read data one cycle after the address
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                ram[8'(i)] <= fillByte(i);
            end
            memRdByte <= '0;
        end else begin
            if (memWe) begin
                ram[memAddr[7:0]] <= memWrByte;
            end
            memRdByte <= ram[memAddr[7:0]];
        end
    end

    function automatic memByteT fillByte(input int idx);
        return memByteT'((idx * 37 + 11) ^ (idx >> 3));
    endfunction

    // little-endian, zero-extended word from the shadow copy
    function automatic wordT refLoad(input addrT addr, input lenT len);
        wordT w;
        addrT a;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            a = addr + addrT'(k);
            w[k*8 +: 8] = shadow[a[7:0]];
        end
        return w;
    endfunction

    function automatic lenT randomLen();
        case ($urandom % 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic stopWithFailure();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic failPlain(input string why);
        $display("Error at time %0t: %s", $time, why);
        stopWithFailure();
    endtask

    task automatic checkWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkByte(input memByteT got, input memByteT exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkOwner(input ownerE got, input ownerE exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %s, expected %s",
                     $time, what, got.name(), exp.name());
            stopWithFailure();
        end
    endtask

    task automatic applyStore(input addrT addr, input lenT len, input wordT wr);
        addrT a;
        for (int k = 0; k < int'(len); k++) begin
            a = addr + addrT'(k);
            shadow[a[7:0]] = wr[k*8 +: 8];
        end
    endtask

    task automatic driveFreeze();
        if (freezeOn) begin
            rdy          = ($urandom % 4) != 0;
            ioBufferFull = ($urandom % 6) == 0;
        end else begin
            rdy          = 1'b1;
            ioBufferFull = 1'b0;
        end
    endtask

    task automatic raiseFetch(input addrT addr);
        instEn   = 1'b1;
        instAddr = addr;
        expInstQ.push_back(refLoad(addr, 3'd4));
        instPending = 1'b1;
    endtask

    task automatic raiseData(input accessE kind);
        lenT  len;
        addrT addr;
        wordT wr;
        len      = randomLen();
        addr     = addrT'($urandom);
        wr       = wordT'($urandom);
        dataEn   = 1'b1;
        dataKind = kind;
        dataLen  = len;
        dataAddr = addr;
        dataWr   = wr;
        if (kind == ACC_LOAD) begin
            expDataQ.push_back(refLoad(addr, len));
            dataIsLoadQ.push_back(1'b1);
        end else begin
            applyStore(addr, len, wr);
            expDataQ.push_back('0);
            dataIsLoadQ.push_back(1'b0);
        end
        dataPending = 1'b1;
    endtask

    task automatic compareRam();
        for (int i = 0; i < 256; i++) begin
            checkByte(ram[8'(i)], shadow[8'(i)], $sformatf("RAM byte %0d", i));
        end
    endtask

    // runs until every raised request saw its done
    task automatic waitDones();
        int   waited;
        logic dropData;
        logic dropInst;
        waited = 0;
        while (dataPending || instPending) begin
            dropData = 1'b0;
            dropInst = 1'b0;
            @(posedge clk);
            waited++;
            if (owner != OWN_NONE) begin
                checkOwner(owner, dataPending ? OWN_DATA : OWN_INST, "owner while busy");
            end
            if (instDone && dataPending) begin
                failPlain("fetch finished before the data transfer that has priority");
            end
            if (dataDone) begin
                dataPending = 1'b0;
                dropData    = 1'b1;
            end
            if (instDone) begin
                instPending = 1'b0;
                dropInst    = 1'b1;
            end
            if (waited > DONE_WAIT) begin
                failPlain("a requested transfer never signalled done");
            end
            @(negedge clk);
            if (dropData) begin
                dataEn = 1'b0;
            end
            if (dropInst) begin
                instEn = 1'b0;
            end
            driveFreeze();
        end
    endtask

    task automatic finishTransfer();
        driveFreeze();
        waitDones();
        compareRam();
    endtask

    task automatic checkIdle();
        repeat (5) begin
            @(posedge clk);
            checkOwner(owner, OWN_NONE, "owner after reset");
            checkWord(memAddr, '0, "RAM address after reset");
            if (instDone || dataDone) begin
                failPlain("a done was high with no request");
            end
            if (memWe) begin
                failPlain("RAM write enable was high with no request");
            end
            @(negedge clk);
        end
    endtask

    function automatic accessE randomKind();
        return (($urandom % 2) == 0) ? ACC_LOAD : ACC_STORE;
    endfunction

    // compares every done against the queued expectation
    always @(posedge clk) begin
        wordT expWord;
        logic isLoad;
        if (!rst) begin
            if (frozen && memWe) begin
                failPlain("RAM write enable was high during a freeze");
            end
            if (frozen && (dataDone || instDone)) begin
                failPlain("a done was high during a freeze");
            end
            if (dataDone && instDone) begin
                failPlain("both dones were high in the same cycle");
            end
            if (instDone) begin
                checkOwner(owner, OWN_INST, "owner at fetch done");
                if (expInstQ.size() == 0) begin
                    failPlain("fetch done without an outstanding fetch");
                end else begin
                    expWord = expInstQ.pop_front();
                    checkWord(instWord, expWord, "fetch word");
                end
            end else begin
                checkWord(instWord, '0, "fetch word outside its done");
            end
            if (dataDone) begin
                checkOwner(owner, OWN_DATA, "owner at data done");
                if (expDataQ.size() == 0) begin
                    failPlain("data done without an outstanding data transfer");
                end else begin
                    expWord = expDataQ.pop_front();
                    isLoad  = dataIsLoadQ.pop_front();
                    if (isLoad) begin
                        checkWord(dataRd, expWord, "load data");
                    end
                end
            end else begin
                checkWord(dataRd, '0, "load data outside its done");
            end
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > TIMEOUT_CYCLES) begin
                $display("Error at time %0t: run went past %0d cycles", $time, TIMEOUT_CYCLES);
                stopWithFailure();
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        instEn       = 1'b0;
        instAddr     = '0;
        dataEn       = 1'b0;
        dataKind     = ACC_LOAD;
        dataLen      = 3'd4;
        dataAddr     = '0;
        dataWr       = '0;
        dataPending  = 1'b0;
        instPending  = 1'b0;
        freezeOn     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[8'(i)] = fillByte(i);
        end

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        checkIdle();

        for (int n = 0; n < NUM_FETCH; n++) begin
            raiseFetch(addrT'($urandom));
            finishTransfer();
        end
        for (int n = 0; n < NUM_LOAD; n++) begin
            raiseData(ACC_LOAD);
            finishTransfer();
        end
        for (int n = 0; n < NUM_STORE; n++) begin
            raiseData(ACC_STORE);
            finishTransfer();
        end
        // data and fetch raised together with data first in the shadow too
        for (int n = 0; n < NUM_PAIR; n++) begin
            raiseData(randomKind());
            raiseFetch(addrT'($urandom));
            finishTransfer();
        end

        freezeOn = 1'b1;
        for (int n = 0; n < NUM_MIXED; n++) begin
            case ($urandom % 3)
                0: raiseFetch(addrT'($urandom));
                1: raiseData(randomKind());
                default: begin
                    raiseData(randomKind());
                    raiseFetch(addrT'($urandom));
                end
            endcase
            finishTransfer();
        end
        freezeOn = 1'b0;
        driveFreeze();
        repeat (4) @(negedge clk);

        if (expInstQ.size() != 0 || expDataQ.size() != 0) begin
            failPlain("some requested transfers never completed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== memCtrl.f ====
verilog/memCtrlPkg.sv
verilog/memArbiter.sv
verilog/memSequencer.sv
verilog/byteAssembler.sv
verilog/memCtrl.sv
tests/tbClockGen.sv
tests/memCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module memCtrlTb -f memCtrl.f -o memCtrlSim

# the simulator exits non-zero on a fatal error, the log decides the result
./obj_dir/memCtrlSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a pass line"
    exit 1
fi
echo "simulation passed"
